//--- all.f
verilog/rob_pkg.sv
verilog/onehot_select.sv
verilog/rob_entry.sv
verilog/rob_commit_sel.sv
verilog/rob_ctrl.sv
verilog/rob_top.sv
sim/rob_checker.sv
sim/tb_rob.sv

//--- Bender.yml
package:
  name: rob

sources:
  - verilog/rob_pkg.sv
  - verilog/onehot_select.sv
  - verilog/rob_entry.sv
  - verilog/rob_commit_sel.sv
  - verilog/rob_ctrl.sv
  - verilog/rob_top.sv
  - target: simulation
    files:
      - sim/rob_checker.sv
      - sim/tb_rob.sv

//--- sim/tb_rob.sv
`default_nettype none

module tb_rob;

  localparam int DEPTH   = rob_pkg::ROB_DEPTH;
  localparam int DISP    = rob_pkg::DISP_SIZE;
  localparam int PORTS   = rob_pkg::DONE_PORTS;
  localparam int IDX_W   = $clog2(DEPTH);
  localparam int LANE_W  = (DISP > 1) ? $clog2(DISP) : 1;
  localparam int CAUSE_W = rob_pkg::CAUSE_W;

  localparam logic [31:0] SEED           = 32'hc4b9;
  localparam int          RESET_CYCLES   = 16;
  localparam int          NUM_GROUPS     = 300;
  localparam int          GROUP_WORST    = 16;  // Slow phase per group, with margin
  localparam int          TIMEOUT_CYCLES = RESET_CYCLES + (NUM_GROUPS + DEPTH) * GROUP_WORST;

  logic                          i_clk;
  logic                          i_reset_n;
  logic                          i_disp_valid;
  logic [DISP-1:0]               i_disp_lanes;
  logic                          o_disp_ready;
  logic [IDX_W:0]                o_disp_cmt_id;
  logic [PORTS-1:0]              i_done_valid;
  logic [PORTS-1:0][IDX_W:0]     i_done_cmt_id;
  logic [PORTS-1:0][LANE_W-1:0]  i_done_lane;
  logic [PORTS-1:0]              i_done_except;
  logic [PORTS-1:0][CAUSE_W-1:0] i_done_cause;
  logic                          i_kill;
  logic                          o_commit_valid;
  logic [IDX_W:0]                o_commit_cmt_id;
  logic [DISP-1:0]               o_commit_lanes;
  logic [DISP-1:0]               o_commit_dead;
  logic                          o_commit_except;
  logic [LANE_W-1:0]             o_commit_except_lane;
  logic [CAUSE_W-1:0]            o_commit_except_cause;

  logic [31:0]     lfsr_state;
  logic [IDX_W:0]  grp_id [$];    // Outstanding groups, oldest first
  logic [DISP-1:0] pend [DEPTH];  // Lanes not yet reported, per entry
  int              dispatched  = 0;
  int              cycle_count = 0;
  int              tb_errors   = 0;
  int              chk_errors;
  int              chk_outstanding;

  always #5 i_clk = ~i_clk;

  rob_top #(.DEPTH(DEPTH), .DISP(DISP), .PORTS(PORTS)) UUT (
    .i_clk                 (i_clk),
    .i_reset_n             (i_reset_n),
    .i_disp_valid          (i_disp_valid),
    .i_disp_lanes          (i_disp_lanes),
    .o_disp_ready          (o_disp_ready),
    .o_disp_cmt_id         (o_disp_cmt_id),
    .i_done_valid          (i_done_valid),
    .i_done_cmt_id         (i_done_cmt_id),
    .i_done_lane           (i_done_lane),
    .i_done_except         (i_done_except),
    .i_done_cause          (i_done_cause),
    .i_kill                (i_kill),
    .o_commit_valid        (o_commit_valid),
    .o_commit_cmt_id       (o_commit_cmt_id),
    .o_commit_lanes        (o_commit_lanes),
    .o_commit_dead         (o_commit_dead),
    .o_commit_except       (o_commit_except),
    .o_commit_except_lane  (o_commit_except_lane),
    .o_commit_except_cause (o_commit_except_cause)
  );

  rob_checker #(.DEPTH(DEPTH), .DISP(DISP), .PORTS(PORTS)) u_checker (
    .i_clk                 (i_clk),
    .i_reset_n             (i_reset_n),
    .i_disp_valid          (i_disp_valid),
    .i_disp_lanes          (i_disp_lanes),
    .i_disp_ready          (o_disp_ready),
    .i_disp_cmt_id         (o_disp_cmt_id),
    .i_done_valid          (i_done_valid),
    .i_done_cmt_id         (i_done_cmt_id),
    .i_done_lane           (i_done_lane),
    .i_done_except         (i_done_except),
    .i_done_cause          (i_done_cause),
    .i_kill                (i_kill),
    .i_commit_valid        (o_commit_valid),
    .i_commit_cmt_id       (o_commit_cmt_id),
    .i_commit_lanes        (o_commit_lanes),
    .i_commit_dead         (o_commit_dead),
    .i_commit_except       (o_commit_except),
    .i_commit_except_lane  (o_commit_except_lane),
    .i_commit_except_cause (o_commit_except_cause),
    .o_errors              (chk_errors),
    .o_outstanding         (chk_outstanding)
  );

  // --------------------
  // Random source
  // --------------------
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // x^32+x^22+x^2+x+1
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int b = 0; b < n; b++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v          = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // --------------------
  // Stimulus
  // --------------------
  task automatic drive_idle();
    i_kill        <= 1'b0;
    i_disp_valid  <= 1'b0;
    i_disp_lanes  <= '0;
    i_done_valid  <= '0;
    i_done_cmt_id <= '0;
    i_done_lane   <= '0;
    i_done_except <= '0;
    i_done_cause  <= '0;
  endtask

  task automatic drive_cycle(input logic draining);
    logic [PORTS-1:0]              vld;
    logic [PORTS-1:0][IDX_W:0]     ids;
    logic [PORTS-1:0][LANE_W-1:0]  lns;
    logic [PORTS-1:0]              exc;
    logic [PORTS-1:0][CAUSE_W-1:0] cau;
    logic [DISP-1:0]               lanes;
    logic [IDX_W-1:0]              idx;
    logic                          slow;
    logic                          found;
    logic                          dvalid;
    logic                          kill;
    int                            g;
    int                            r;
    int                            pick;
    vld  = '0;
    ids  = '0;
    lns  = '0;
    exc  = '0;
    cau  = '0;
    slow = cycle_count[6] && !draining;  // Slow phases let the buffer fill
    for (int p = 0; p < PORTS; p++) begin
      if (grp_id.size() > 0 && rand_bits(slow ? 3 : 1) == 0) begin
        g     = rand_bits(IDX_W) % grp_id.size();
        r     = rand_bits(LANE_W) % DISP;
        found = 1'b0;
        for (int n = 0; n < grp_id.size() && !found; n++) begin
          pick = (g + n) % grp_id.size();
          idx  = grp_id[pick][IDX_W-1:0];
          for (int k = 0; k < DISP && !found; k++) begin
            if (pend[idx][(r + k) % DISP]) begin
              found                     = 1'b1;
              pend[idx][(r + k) % DISP] = 1'b0;
              vld[p]                    = 1'b1;
              ids[p]                    = grp_id[pick];
              lns[p]                    = LANE_W'((r + k) % DISP);
              exc[p]                    = (rand_bits(3) == 0);  // About 1 in 8
              cau[p]                    = CAUSE_W'(rand_bits(CAUSE_W));
            end
          end
        end
      end
    end
    dvalid = !draining && grp_id.size() < DEPTH && rand_bits(2) != 0;
    lanes  = DISP'(rand_bits(DISP));
    if (lanes == '0) begin
      lanes = '1;
    end
    kill = !draining && rand_bits(6) == 0;
    i_kill        <= kill;
    i_disp_valid  <= dvalid;
    i_disp_lanes  <= lanes;
    i_done_valid  <= vld;
    i_done_cmt_id <= ids;
    i_done_lane   <= lns;
    i_done_except <= exc;
    i_done_cause  <= cau;
  endtask

  // Group list follows accepted dispatches, commits, flushes and kills
  always @(negedge i_clk) begin
    if (i_reset_n) begin
      if (i_kill || (o_commit_valid && o_commit_except)) begin
        grp_id.delete();
      end else if (o_commit_valid && grp_id.size() > 0) begin
        void'(grp_id.pop_front());
      end
      if (i_disp_valid && o_disp_ready && !i_kill && !(o_commit_valid && o_commit_except)) begin
        grp_id.push_back(o_disp_cmt_id);
        pend[o_disp_cmt_id[IDX_W-1:0]] = i_disp_lanes;
        dispatched++;
      end
    end
  end

  // --------------------
  // End of run
  // --------------------
  task automatic report_and_finish();
    $display("Error count: checker %0d, testbench %0d", chk_errors, tb_errors);
    if (chk_errors == 0 && tb_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  endtask

  always @(posedge i_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, %0d groups never committed", cycle_count,
               grp_id.size());
      tb_errors++;
      report_and_finish();
    end
  end

  initial begin
    i_clk      = 1'b0;
    i_reset_n  = 1'b0;
    lfsr_state = SEED;
    drive_idle();
    repeat (RESET_CYCLES) @(posedge i_clk);
    i_reset_n <= 1'b1;
    while (dispatched < NUM_GROUPS || grp_id.size() > 0) begin
      @(posedge i_clk);
      drive_cycle(dispatched >= NUM_GROUPS);
    end
    @(posedge i_clk);
    drive_idle();
    repeat (4) @(posedge i_clk);
    if (chk_outstanding != 0) begin
      $display("Model still holds %0d groups that never committed", chk_outstanding);
      tb_errors++;
    end
    report_and_finish();
  end

endmodule

`default_nettype wire

//--- sim/rob_checker.sv
`default_nettype none

module rob_checker #(
  parameter  int DEPTH  = rob_pkg::ROB_DEPTH,
  parameter  int DISP   = rob_pkg::DISP_SIZE,
  parameter  int PORTS  = rob_pkg::DONE_PORTS,
  localparam int IDX_W  = $clog2(DEPTH),
  localparam int LANE_W = (DISP > 1) ? $clog2(DISP) : 1,
  localparam int CW     = rob_pkg::CAUSE_W
) (
  input  logic                         i_clk,
  input  logic                         i_reset_n,
  input  logic                         i_disp_valid,
  input  logic [DISP-1:0]              i_disp_lanes,
  input  logic                         i_disp_ready,
  input  logic [IDX_W:0]               i_disp_cmt_id,
  input  logic [PORTS-1:0]             i_done_valid,
  input  logic [PORTS-1:0][IDX_W:0]    i_done_cmt_id,
  input  logic [PORTS-1:0][LANE_W-1:0] i_done_lane,
  input  logic [PORTS-1:0]             i_done_except,
  input  logic [PORTS-1:0][CW-1:0]     i_done_cause,
  input  logic                         i_kill,
  input  logic                         i_commit_valid,
  input  logic [IDX_W:0]               i_commit_cmt_id,
  input  logic [DISP-1:0]              i_commit_lanes,
  input  logic [DISP-1:0]              i_commit_dead,
  input  logic                         i_commit_except,
  input  logic [LANE_W-1:0]            i_commit_except_lane,
  input  logic [CW-1:0]                i_commit_except_cause,
  output int                           o_errors,
  output int                           o_outstanding
);

  logic [IDX_W:0]  q_id [$];  // Allocated groups, oldest first
  logic [IDX_W:0]  next_id;
  logic [DISP-1:0] m_lanes [DEPTH];
  logic [DISP-1:0] m_done  [DEPTH];
  logic [DISP-1:0] m_dead  [DEPTH];
  logic [DISP-1:0] m_exc   [DEPTH];
  logic [CW-1:0]   m_cause [DEPTH][DISP];
  int              errors = 0;

  assign o_errors = errors;

  task automatic compare_field(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (actual !== expected) begin
      $display("Error %s: expected %0h, got %0h at %0t", name, expected, actual, $time);
      errors++;
    end
  endtask

  // Inputs and outputs of the cycle are stable at the falling edge
  always @(negedge i_clk) begin : model
    int              h;
    int              e;
    int              l;
    logic            exp_commit;
    logic            flush;
    logic            accept;
    logic            above;
    logic [DISP-1:0] live;
    logic [DISP-1:0] new_exc [DEPTH];
    if (!i_reset_n) begin
      q_id.delete();
      next_id = '0;
    end else begin
      compare_field("o_disp_ready", q_id.size() < DEPTH, i_disp_ready);
      compare_field("o_disp_cmt_id", next_id, i_disp_cmt_id);

      // --------------------
      // Commit check
      // --------------------
      live       = '0;
      exp_commit = 1'b0;
      if (q_id.size() > 0) begin
        h          = q_id[0][IDX_W-1:0];
        live       = m_exc[h] & ~m_dead[h] & m_lanes[h];
        exp_commit = !i_kill && (((m_done[h] | m_dead[h]) & m_lanes[h]) == m_lanes[h]);
      end
      if (i_commit_valid && !exp_commit) begin
        $display("Unexpected commit of id %0h at %0t", i_commit_cmt_id, $time);
        errors++;
      end else if (!i_commit_valid && exp_commit) begin
        $display("Group %0h is complete but did not commit at %0t", q_id[0], $time);
        errors++;
      end else if (exp_commit) begin
        compare_field("o_commit_cmt_id", q_id[0], i_commit_cmt_id);
        compare_field("o_commit_lanes", m_lanes[h], i_commit_lanes);
        compare_field("o_commit_dead", m_dead[h], i_commit_dead);
        compare_field("o_commit_except", |live, i_commit_except);
        if (|live) begin
          l = 0;
          while (!live[l]) l++;  // Lowest live exception
          compare_field("o_commit_except_lane", l, i_commit_except_lane);
          compare_field("o_commit_except_cause", m_cause[h][l], i_commit_except_cause);
        end
      end
      flush  = exp_commit && (|live);
      accept = i_disp_valid && (q_id.size() < DEPTH) && !i_kill && !flush;

      // --------------------
      // Model update
      // --------------------
      if (i_kill) begin
        if (q_id.size() > 0) begin
          next_id = q_id[0];
        end
        q_id.delete();
      end else begin
        for (int x = 0; x < DEPTH; x++) begin
          new_exc[x] = '0;
        end
        for (int p = 0; p < PORTS; p++) begin
          if (i_done_valid[p]) begin
            e            = i_done_cmt_id[p][IDX_W-1:0];
            l            = i_done_lane[p];
            m_done[e][l] = 1'b1;
            if (!m_dead[e][l]) begin  // Dead lanes only count as done
              m_exc[e][l]   = i_done_except[p];
              m_cause[e][l] = i_done_cause[p];
              new_exc[e][l] = i_done_except[p];
            end
          end
        end
        for (int x = 0; x < DEPTH; x++) begin
          above = 1'b0;
          for (int d = 0; d < DISP; d++) begin
            if (above) begin
              m_dead[x][d] = m_dead[x][d] | m_lanes[x][d];
            end
            above = above | new_exc[x][d];
          end
        end
        if (flush) begin
          next_id = q_id[0] + 1'b1;  // Younger groups are gone
          q_id.delete();
        end else if (exp_commit) begin
          void'(q_id.pop_front());
        end
      end
      if (accept) begin
        h          = next_id[IDX_W-1:0];
        m_lanes[h] = i_disp_lanes;
        m_done[h]  = '0;
        m_dead[h]  = '0;
        m_exc[h]   = '0;
        q_id.push_back(next_id);
        next_id    = next_id + 1'b1;
      end
    end
    o_outstanding = q_id.size();
  end

endmodule

`default_nettype wire

//--- verilog/rob_top.sv
`default_nettype none

module rob_top #(
  parameter  int DEPTH  = rob_pkg::ROB_DEPTH,
  parameter  int DISP   = rob_pkg::DISP_SIZE,
  parameter  int PORTS  = rob_pkg::DONE_PORTS,
  localparam int IDX_W  = $clog2(DEPTH),
  localparam int LANE_W = (DISP > 1) ? $clog2(DISP) : 1
) (
  input  logic                                  i_clk,
  input  logic                                  i_reset_n,
  input  logic                                  i_disp_valid,
  input  logic [DISP-1:0]                       i_disp_lanes,
  output logic                                  o_disp_ready,
  output logic [IDX_W:0]                        o_disp_cmt_id,
  input  logic [PORTS-1:0]                      i_done_valid,
  input  logic [PORTS-1:0][IDX_W:0]             i_done_cmt_id,
  input  logic [PORTS-1:0][LANE_W-1:0]          i_done_lane,
  input  logic [PORTS-1:0]                      i_done_except,
  input  logic [PORTS-1:0][rob_pkg::CAUSE_W-1:0] i_done_cause,
  input  logic                                  i_kill,
  output logic                                  o_commit_valid,
  output logic [IDX_W:0]                        o_commit_cmt_id,
  output logic [DISP-1:0]                       o_commit_lanes,
  output logic [DISP-1:0]                       o_commit_dead,
  output logic                                  o_commit_except,
  output logic [LANE_W-1:0]                     o_commit_except_lane,
  output logic [rob_pkg::CAUSE_W-1:0]           o_commit_except_cause
);

  // Report record widths are fixed by the package defaults
  if (DEPTH != rob_pkg::ROB_DEPTH || DISP != rob_pkg::DISP_SIZE) begin : g_size_check
    $error("rob_top: DEPTH and DISP must match the rob_pkg defaults");
  end

  rob_pkg::done_rpt_t                               w_done_rpt [PORTS];
  logic [DEPTH-1:0]                                 w_load;
  logic [DISP-1:0]                                  w_load_lanes;
  logic                                             w_load_msb;
  logic [DEPTH-1:0]                                 w_commit_finish;
  logic [DEPTH-1:0]                                 w_flush;
  logic [IDX_W-1:0]                                 w_head;
  logic [DEPTH-1:0]                                 w_entry_valid;
  logic [DEPTH-1:0]                                 w_entry_all_done;
  logic [DEPTH-1:0][DISP-1:0]                       w_entry_lanes;
  logic [DEPTH-1:0][DISP-1:0]                       w_entry_done;
  logic [DEPTH-1:0][DISP-1:0]                       w_entry_dead;
  logic [DEPTH-1:0][DISP-1:0]                       w_entry_except;
  logic [DEPTH-1:0][DISP-1:0][rob_pkg::CAUSE_W-1:0] w_entry_cause;
  logic [DEPTH-1:0]                                 w_entry_msb;

  for (genvar p = 0; p < PORTS; p++) begin : g_rpt
    assign w_done_rpt[p] = '{valid  : i_done_valid[p],
                             cmt_id : i_done_cmt_id[p],
                             lane   : i_done_lane[p],
                             except : i_done_except[p],
                             cause  : i_done_cause[p]};
  end

  rob_ctrl #(.DEPTH(DEPTH), .DISP(DISP)) u_ctrl (
    .i_clk            (i_clk),
    .i_reset_n        (i_reset_n),
    .i_disp_valid     (i_disp_valid),
    .i_disp_lanes     (i_disp_lanes),
    .i_kill           (i_kill),
    .i_entry_valid    (w_entry_valid),
    .i_entry_all_done (w_entry_all_done),
    .i_head_except    (o_commit_except),
    .o_disp_ready     (o_disp_ready),
    .o_disp_cmt_id    (o_disp_cmt_id),
    .o_load           (w_load),
    .o_load_lanes     (w_load_lanes),
    .o_load_msb       (w_load_msb),
    .o_commit_finish  (w_commit_finish),
    .o_flush          (w_flush),
    .o_head           (w_head),
    .o_commit_valid   (o_commit_valid)
  );

  for (genvar e = 0; e < DEPTH; e++) begin : g_entry
    rob_entry #(.DEPTH(DEPTH), .DISP(DISP), .PORTS(PORTS)) u_entry (
      .i_clk           (i_clk),
      .i_reset_n       (i_reset_n),
      .i_index         (IDX_W'(e)),
      .i_load          (w_load[e]),
      .i_load_lanes    (w_load_lanes),
      .i_load_msb      (w_load_msb),
      .i_done_rpt      (w_done_rpt),
      .i_commit_finish (w_commit_finish[e]),
      .i_flush         (w_flush[e]),
      .o_valid         (w_entry_valid[e]),
      .o_all_done      (w_entry_all_done[e]),
      .o_lanes         (w_entry_lanes[e]),
      .o_done          (w_entry_done[e]),
      .o_dead          (w_entry_dead[e]),
      .o_except        (w_entry_except[e]),
      .o_cause         (w_entry_cause[e]),
      .o_msb           (w_entry_msb[e])
    );
  end

  rob_commit_sel #(.DEPTH(DEPTH), .DISP(DISP)) u_commit_sel (
    .i_head         (w_head),
    .i_entry_lanes  (w_entry_lanes),
    .i_entry_done   (w_entry_done),
    .i_entry_dead   (w_entry_dead),
    .i_entry_except (w_entry_except),
    .i_entry_cause  (w_entry_cause),
    .i_entry_msb    (w_entry_msb),
    .o_lanes        (o_commit_lanes),
    .o_dead         (o_commit_dead),
    .o_cmt_id       (o_commit_cmt_id),
    .o_except       (o_commit_except),
    .o_except_lane  (o_commit_except_lane),
    .o_except_cause (o_commit_except_cause)
  );

endmodule

`default_nettype wire

//--- verilog/rob_ctrl.sv
`default_nettype none

module rob_ctrl #(
  parameter  int DEPTH = rob_pkg::ROB_DEPTH,
  parameter  int DISP  = rob_pkg::DISP_SIZE,
  localparam int IDX_W = $clog2(DEPTH)
) (
  input  logic             i_clk,
  input  logic             i_reset_n,
  input  logic             i_disp_valid,
  input  logic [DISP-1:0]  i_disp_lanes,
  input  logic             i_kill,
  input  logic [DEPTH-1:0] i_entry_valid,
  input  logic [DEPTH-1:0] i_entry_all_done,
  input  logic             i_head_except,
  output logic             o_disp_ready,
  output logic [IDX_W:0]   o_disp_cmt_id,
  output logic [DEPTH-1:0] o_load,
  output logic [DISP-1:0]  o_load_lanes,
  output logic             o_load_msb,
  output logic [DEPTH-1:0] o_commit_finish,
  output logic [DEPTH-1:0] o_flush,
  output logic [IDX_W-1:0] o_head,
  output logic             o_commit_valid
);

  logic [IDX_W:0]   r_head;  // Wrap bit on top
  logic [IDX_W:0]   r_tail;
  logic [IDX_W-1:0] w_head_idx;
  logic [IDX_W-1:0] w_tail_idx;
  logic             w_full;
  logic             w_empty;
  logic             w_commit;
  logic             w_except_flush;
  logic             w_alloc;

  assign w_head_idx = r_head[IDX_W-1:0];
  assign w_tail_idx = r_tail[IDX_W-1:0];
  assign w_empty    = (r_head == r_tail);
  assign w_full     = (w_head_idx == w_tail_idx) && (r_head[IDX_W] != r_tail[IDX_W]);

  // --------------------
  // Commit and flush
  // --------------------
  assign w_commit       = i_entry_all_done[w_head_idx] && !i_kill;
  assign w_except_flush = w_commit && i_head_except;

  assign o_commit_valid  = w_commit;
  assign o_head          = w_head_idx;
  assign o_commit_finish = w_commit ? (DEPTH'(1) << w_head_idx) : '0;

  always_comb begin
    o_flush = '0;
    if (i_kill) begin
      o_flush = '1;
    end else if (w_except_flush) begin
      o_flush = ~(DEPTH'(1) << w_head_idx);  // Everything younger than head
    end
  end

  // --------------------
  // Allocation
  // --------------------
  // Dropped while the buffer is being cleared
  assign w_alloc = i_disp_valid && o_disp_ready && !i_kill && !w_except_flush;

  assign o_disp_ready  = !w_full;
  assign o_disp_cmt_id = r_tail;
  assign o_load        = w_alloc ? (DEPTH'(1) << w_tail_idx) : '0;
  assign o_load_lanes  = i_disp_lanes;
  assign o_load_msb    = r_tail[IDX_W];

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_head <= '0;
      r_tail <= '0;
    end else if (i_kill) begin
      r_tail <= r_head;
    end else begin
      if (w_commit) begin
        r_head <= r_head + 1'b1;
      end
      if (w_except_flush) begin
        r_tail <= r_head + 1'b1;
      end else if (w_alloc) begin
        r_tail <= r_tail + 1'b1;
      end
    end
  end

  // --------------------
  // Checks
  // --------------------
  a_disp_when_full : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_disp_valid |-> o_disp_ready)
    else $error("rob_ctrl: dispatch while full");

  a_commit_head_valid : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_commit_valid |-> (!w_empty && i_entry_valid[w_head_idx]))
    else $error("rob_ctrl: commit of invalid head %0d", w_head_idx);

  a_empty_no_valid : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    w_empty |-> (i_entry_valid == '0))
    else $error("rob_ctrl: entries valid in empty buffer %b", i_entry_valid);

endmodule

`default_nettype wire

//--- verilog/rob_commit_sel.sv
`default_nettype none

module rob_commit_sel #(
  parameter  int DEPTH  = rob_pkg::ROB_DEPTH,
  parameter  int DISP   = rob_pkg::DISP_SIZE,
  localparam int IDX_W  = $clog2(DEPTH),
  localparam int LANE_W = (DISP > 1) ? $clog2(DISP) : 1
) (
  input  logic [IDX_W-1:0]                                  i_head,
  input  logic [DEPTH-1:0][DISP-1:0]                        i_entry_lanes,
  input  logic [DEPTH-1:0][DISP-1:0]                        i_entry_done,
  input  logic [DEPTH-1:0][DISP-1:0]                        i_entry_dead,
  input  logic [DEPTH-1:0][DISP-1:0]                        i_entry_except,
  input  logic [DEPTH-1:0][DISP-1:0][rob_pkg::CAUSE_W-1:0]  i_entry_cause,
  input  logic [DEPTH-1:0]                                  i_entry_msb,
  output logic [DISP-1:0]                                   o_lanes,
  output logic [DISP-1:0]                                   o_dead,
  output logic [IDX_W:0]                                    o_cmt_id,
  output logic                                              o_except,
  output logic [LANE_W-1:0]                                 o_except_lane,
  output logic [rob_pkg::CAUSE_W-1:0]                       o_except_cause
);

  // Flat entry record {lanes, done, dead, except, causes, msb}
  localparam int REC_W = 4 * DISP + DISP * rob_pkg::CAUSE_W + 1;
  typedef logic [REC_W-1:0] rec_t;

  logic [DEPTH-1:0]                      w_head_oh;
  rec_t                                  w_rec [DEPTH];
  rec_t                                  w_head_rec;
  logic [DISP-1:0]                       w_h_done;
  logic [DISP-1:0]                       w_h_except;
  logic [DISP-1:0][rob_pkg::CAUSE_W-1:0] w_h_cause;
  logic                                  w_h_msb;
  logic [DISP-1:0]                       w_live_except;

  assign w_head_oh = DEPTH'(1) << i_head;

  for (genvar e = 0; e < DEPTH; e++) begin : g_rec
    assign w_rec[e] = {i_entry_lanes[e], i_entry_done[e], i_entry_dead[e],
                       i_entry_except[e], i_entry_cause[e], i_entry_msb[e]};
  end

  onehot_select #(
    .T     (rec_t),
    .WORDS (DEPTH)
  ) u_head_sel (
    .i_sel      (w_head_oh),
    .i_data     (w_rec),
    .o_selected (w_head_rec)
  );

  assign {o_lanes, w_h_done, o_dead, w_h_except, w_h_cause, w_h_msb} = w_head_rec;

  assign o_cmt_id = {w_h_msb, i_head};

  // --------------------
  // First exception
  // --------------------
  // Dead lanes never raise, even if a report set their flag
  assign w_live_except = w_h_except & w_h_done & ~o_dead & o_lanes;
  assign o_except      = |w_live_except;

  always_comb begin
    o_except_lane  = '0;
    o_except_cause = '0;
    for (int d = DISP - 1; d >= 0; d--) begin  // Lowest lane wins
      if (w_live_except[d]) begin
        o_except_lane  = LANE_W'(d);
        o_except_cause = w_h_cause[d];
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/rob_entry.sv
`default_nettype none

module rob_entry #(
  parameter  int DEPTH  = rob_pkg::ROB_DEPTH,
  parameter  int DISP   = rob_pkg::DISP_SIZE,
  parameter  int PORTS  = rob_pkg::DONE_PORTS,
  localparam int IDX_W  = $clog2(DEPTH)
) (
  input  logic                                  i_clk,
  input  logic                                  i_reset_n,
  input  logic [IDX_W-1:0]                      i_index,
  input  logic                                  i_load,
  input  logic [DISP-1:0]                       i_load_lanes,
  input  logic                                  i_load_msb,
  input  rob_pkg::done_rpt_t                    i_done_rpt [PORTS],
  input  logic                                  i_commit_finish,
  input  logic                                  i_flush,
  output logic                                  o_valid,
  output logic                                  o_all_done,
  output logic [DISP-1:0]                       o_lanes,
  output logic [DISP-1:0]                       o_done,
  output logic [DISP-1:0]                       o_dead,
  output logic [DISP-1:0]                       o_except,
  output logic [DISP-1:0][rob_pkg::CAUSE_W-1:0] o_cause,
  output logic                                  o_msb
);

  logic                                  r_valid;
  logic [DISP-1:0]                       r_lanes;
  logic [DISP-1:0]                       r_done;
  logic [DISP-1:0]                       r_dead;
  logic [DISP-1:0]                       r_except;
  logic [DISP-1:0][rob_pkg::CAUSE_W-1:0] r_cause;
  logic                                  r_msb;

  logic [DISP-1:0]                       w_rpt_hit;     // Some port reports this lane
  logic [DISP-1:0]                       w_rpt_except;
  logic [DISP-1:0][rob_pkg::CAUSE_W-1:0] w_rpt_cause;
  logic [DISP-1:0]                       w_rpt_record;  // Hit on a lane still alive
  logic [DISP-1:0]                       w_new_except;
  logic [DISP-1:0]                       w_tree_dead;

  // --------------------
  // Report match
  // --------------------
  for (genvar d = 0; d < DISP; d++) begin : g_lane
    logic [PORTS-1:0]   w_hit;
    rob_pkg::done_rpt_t w_sel;

    for (genvar p = 0; p < PORTS; p++) begin : g_port
      assign w_hit[p] = i_done_rpt[p].valid &&
                        (i_done_rpt[p].cmt_id[IDX_W-1:0] == i_index) &&
                        (i_done_rpt[p].lane == d);
    end

    onehot_select #(
      .T     (rob_pkg::done_rpt_t),
      .WORDS (PORTS)
    ) u_rpt_sel (
      .i_sel      (w_hit),
      .i_data     (i_done_rpt),
      .o_selected (w_sel)
    );

    assign w_rpt_hit[d]    = |w_hit;
    assign w_rpt_except[d] = w_sel.except;
    assign w_rpt_cause[d]  = w_sel.cause;

    // One report per lane, and only into a live group lane
    a_done_match : assert property (@(posedge i_clk) disable iff (!i_reset_n)
      (|w_hit) |-> ($onehot(w_hit) && r_valid && r_lanes[d]))
      else $error("rob_entry %0d lane %0d: bad done match %b", i_index, d, w_hit);
  end

  assign w_rpt_record = w_rpt_hit & ~r_dead;
  assign w_new_except = w_rpt_record & w_rpt_except & r_lanes;

  // Lower-set tree, every lane above an excepting one dies
  always_comb begin
    logic acc;
    acc = 1'b0;
    for (int d = 0; d < DISP; d++) begin
      w_tree_dead[d] = acc;
      acc            = acc | w_new_except[d];
    end
  end

  // --------------------
  // State
  // --------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid  <= 1'b0;
      r_done   <= '0;
      r_dead   <= '0;
      r_except <= '0;
    end else if (i_load) begin
      r_valid  <= 1'b1;
      r_done   <= '0;
      r_dead   <= '0;
      r_except <= '0;
    end else if (i_flush || (i_commit_finish && o_all_done)) begin
      r_valid <= 1'b0;
    end else if (r_valid) begin
      r_done   <= r_done | w_rpt_hit;
      r_dead   <= r_dead | (w_tree_dead & r_lanes);
      r_except <= (r_except & ~w_rpt_record) | (w_rpt_except & w_rpt_record);
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_load) begin
      r_lanes <= i_load_lanes;
      r_msb   <= i_load_msb;
    end
    for (int d = 0; d < DISP; d++) begin
      if (r_valid && w_rpt_record[d]) begin
        r_cause[d] <= w_rpt_cause[d];
      end
    end
  end

  assign o_valid    = r_valid;
  assign o_all_done = r_valid && (((r_done | r_dead) & r_lanes) == r_lanes);
  assign o_lanes    = r_lanes;
  assign o_done     = r_done;
  assign o_dead     = r_dead;
  assign o_except   = r_except;
  assign o_cause    = r_cause;
  assign o_msb      = r_msb;

endmodule

`default_nettype wire

//--- verilog/onehot_select.sv
`default_nettype none

module onehot_select #(
  parameter type T     = logic,
  parameter int  WORDS = 2
) (
  input  logic [WORDS-1:0] i_sel,
  input  T                 i_data [WORDS],
  output T                 o_selected
);

  // OR of every payload whose select bit is set
  always_comb begin
    o_selected = '0;
    for (int w = 0; w < WORDS; w++) begin
      if (i_sel[w]) begin
        o_selected = o_selected | i_data[w];
      end
    end
  end

  // --------------------
  // Checks
  // --------------------
  // More than one bit set would merge two payloads silently
  always_comb begin
    if (!$isunknown(i_sel)) begin
      a_sel_onehot0 : assert final ($onehot0(i_sel))
        else $error("onehot_select: select %b is not one-hot", i_sel);
    end
  end

endmodule

`default_nettype wire

//--- verilog/rob_pkg.sv
`default_nettype none

package rob_pkg;

  // --------------------
  // Default sizes
  // --------------------
  localparam int DISP_SIZE  = 2;  // Lanes per dispatch group
  localparam int ROB_DEPTH  = 8;  // Entries, power of two
  localparam int DONE_PORTS = 3;  // Completion report ports

  localparam int CAUSE_W = 4;

  // --------------------
  // Completion report
  // --------------------
  // The commit id keeps one wrap bit above the entry index. The field
  // widths follow the defaults above, so rob_top refuses other sizes.
  typedef struct packed {
    logic                                            valid;
    logic [$clog2(ROB_DEPTH):0]                      cmt_id;
    logic [((DISP_SIZE > 1) ? $clog2(DISP_SIZE) : 1)-1:0] lane;
    logic                                            except;
    logic [CAUSE_W-1:0]                              cause;
  } done_rpt_t;

endpackage

`default_nettype wire
